// File: project.f
soc_ctrl_pkg.sv
apb_slave_port.sv
pad_ctrl_regs.sv
boot_cluster_regs.sv
core_status_regs.sv
apb_soc_ctrl.sv
soc_ctrl_assertions.sv
tb_apb_soc_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the result from the log.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
   -f project.f --top-module tb_apb_soc_ctrl -o sim_apb_soc_ctrl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_apb_soc_ctrl > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "sim failed" "$log"; then
   exit 1
fi
exit 0

// File: tb_apb_soc_ctrl.sv
/*
 * Testbench for the APB SoC control block
 * table of register accesses, then side-band fetch enable and JTAG steps
 */
`timescale 1ns/1ns
`default_nettype none

module tb_apb_soc_ctrl;
   import soc_ctrl_pkg::*;

   typedef struct packed {
      logic        wr;
      reg_addr_e   idx;
      logic [31:0] wdata;
      logic [31:0] exp;  // read word, ignored on writes
   } entry_t;

   localparam int ready_timeout = 16;

   logic                  HCLK = 1'b0;
   logic                  HRESETn;
   logic [apb_addr_w-1:0] paddr_i;
   logic [31:0]           pwdata_i;
   logic                  pwrite_i;
   logic                  psel_i;
   logic                  penable_i;
   logic [31:0]           prdata_o;
   logic                  pready_o;
   logic                  pslverr_o;
   logic                  fc_fetch_en_valid_i;
   logic                  fc_fetch_en_i;
   pad_mux_t              pad_mux_o;
   pad_cfg_t              pad_cfg_o;
   logic [jtag_w-1:0]     soc_jtag_reg_i;
   logic [jtag_w-1:0]     soc_jtag_reg_o;
   logic [31:0]           fc_bootaddr_o;
   logic                  fc_fetchen_o;
   cluster_ctrl_t         cluster_ctrl_o;
   logic [63:0]           cluster_boot_addr_o;

   entry_t        tbl[$];
   logic [31:0]   shadow [0:(1 << reg_idx_w) - 1];  // expected read word per index
   pad_mux_t      mux_m;
   pad_cfg_t      cfg_m;
   cluster_ctrl_t cl_m;
   logic [31:0]   boot_m;
   logic [63:0]   clboot_m;
   int            pass_cnt = 0;
   int            fail_cnt = 0;
   int            test_no = 0;
   logic          test_ok;

   apb_soc_ctrl dut0 (.*);

   always #5 HCLK = ~HCLK;

   function automatic reg_addr_e offset_idx(input reg_addr_e base, input int k);
      return reg_addr_e'(int'(base) + k);
   endfunction

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
         test_ok = 1'b0;
      end
   endtask

   task automatic check_pad_mux(input pad_mux_t got, input pad_mux_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: pad_mux_o is %032h, expected %032h", $time, got, exp);
         test_ok = 1'b0;
      end
   endtask

   task automatic check_pad_cfg(input pad_cfg_t got, input pad_cfg_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: pad_cfg_o is %096h, expected %096h", $time, got, exp);
         test_ok = 1'b0;
      end
   endtask

   task automatic check_cluster(input cluster_ctrl_t got, input cluster_ctrl_t exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t: cluster_ctrl_o is %04b, expected %04b", $time, got, exp);
         test_ok = 1'b0;
      end
   endtask

   task automatic check_outputs;
      check_pad_mux(pad_mux_o, mux_m);
      check_pad_cfg(pad_cfg_o, cfg_m);
      check_cluster(cluster_ctrl_o, cl_m);
      check_word("fc_bootaddr_o", fc_bootaddr_o, boot_m);
      check_word("cluster boot low", cluster_boot_addr_o[31:0], clboot_m[31:0]);
      check_word("cluster boot high", cluster_boot_addr_o[63:32], clboot_m[63:32]);
   endtask

   task automatic end_test(input string name);
      test_no++;
      if (test_ok)
         pass_cnt++;
      else
         fail_cnt++;
      $display("test %0d %s: %s", test_no, name, test_ok ? "ok" : "FAILED");
   endtask

   task automatic add_rd(input reg_addr_e idx);
      tbl.push_back(entry_t'{wr: 1'b0, idx: idx, wdata: 32'h0, exp: shadow[idx]});
   endtask

   // expected readback follows the register map rules
   task automatic add_wr(input reg_addr_e idx, input logic [31:0] d);
      int k;
      k = int'(idx);
      tbl.push_back(entry_t'{wr: 1'b1, idx: idx, wdata: d, exp: 32'h0});
      if (idx == reg_fcboot || idx == reg_cluster_boot0 || idx == reg_cluster_boot1)
         shadow[idx] = d;
      else if (idx == reg_cluster_ctrl)
         shadow[idx] = {28'h0, d[3:0]};
      else if (idx == reg_corestatus)
      begin
         shadow[reg_corestatus] = d;
         shadow[reg_cs_ro]      = d;  // mirror follows
      end
      else if (k >= int'(reg_padfun0) && k <= int'(reg_padfun3))
         shadow[idx] = d;
      else if (k >= int'(reg_padcfg0) && k <= int'(reg_padcfg15))
         shadow[idx] = d & 32'h3F3F3F3F;  // six bits per lane
   endtask

   task automatic add_unmapped(input logic [reg_idx_w-1:0] raw);
      add_rd(reg_addr_e'(raw));
      add_wr(reg_addr_e'(raw), 32'hFFFFFFFF);
      add_rd(reg_addr_e'(raw));
   endtask

   task automatic model_write(input entry_t e);
      int k;
      k = int'(e.idx);
      if (k >= int'(reg_padfun0) && k <= int'(reg_padfun3))
         for (int p = 0; p < pads_per_fun_word; p++)
            mux_m[(k - int'(reg_padfun0)) * pads_per_fun_word + p] = e.wdata[2*p +: 2];
      if (k >= int'(reg_padcfg0) && k <= int'(reg_padcfg15))
         for (int j = 0; j < pads_per_cfg_word; j++)
            cfg_m[(k - int'(reg_padcfg0)) * pads_per_cfg_word + j] =
               e.wdata[8*j +: padcfg_w];
      case (e.idx)
         reg_fcboot:        boot_m = e.wdata;
         reg_cluster_boot0: clboot_m[31:0] = e.wdata;
         reg_cluster_boot1: clboot_m[63:32] = e.wdata;
         reg_cluster_ctrl:
         begin
            cl_m.rstn     = e.wdata[3];
            cl_m.fetch_en = e.wdata[2];
            cl_m.pow      = e.wdata[1];
            cl_m.byp      = e.wdata[0];
         end
         default: ;
      endcase
   endtask

   // setup cycle, then access cycle, optionally with a side-band strobe
   task automatic apb_access(input logic wr, input reg_addr_e idx, input logic [31:0] wdata,
                             input logic strobe, output logic [31:0] rdata);
      int n;
      @(posedge HCLK);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= wr;
      paddr_i   <= apb_addr_w'({idx, 2'b00});
      pwdata_i  <= wdata;
      @(posedge HCLK);
      penable_i           <= 1'b1;
      fc_fetch_en_valid_i <= strobe;
      fc_fetch_en_i       <= strobe;
      n = 0;
      @(negedge HCLK);
      while (pready_o !== 1'b1 && n < ready_timeout)
      begin
         @(negedge HCLK);
         n++;
      end
      if (pready_o !== 1'b1)
      begin
         $display("%0t: timeout, PREADY stayed low on index %02h", $time, idx);
         test_ok = 1'b0;
      end
      rdata = prdata_o;
      @(posedge HCLK);
      psel_i              <= 1'b0;
      penable_i           <= 1'b0;
      pwrite_i            <= 1'b0;
      fc_fetch_en_valid_i <= 1'b0;
      fc_fetch_en_i       <= 1'b0;
   endtask

   initial
   begin
      logic [31:0]       rd;
      logic [jtag_w-1:0] jtag_val;
      void'($urandom(32'h61b1c280));
      HRESETn             <= 1'b0;
      paddr_i             <= '0;
      pwdata_i            <= '0;
      pwrite_i            <= 1'b0;
      psel_i              <= 1'b0;
      penable_i           <= 1'b0;
      fc_fetch_en_valid_i <= 1'b0;
      fc_fetch_en_i       <= 1'b0;
      soc_jtag_reg_i      <= '0;
      foreach (shadow[i])
         shadow[i] = 32'h0;
      shadow[reg_info]         = 32'h00040000;  // four cores, no clusters
      shadow[reg_fcboot]       = fc_boot_rst;
      shadow[reg_cluster_ctrl] = {28'h0, 4'b1001};  // reset released, bypass on
      for (int k = 0; k < n_pads / pads_per_cfg_word; k++)
         shadow[offset_idx(reg_padcfg0, k)] = 32'h3F3F3F3F;
      mux_m    = '0;
      cfg_m    = '1;
      boot_m   = fc_boot_rst;
      clboot_m = '0;
      cl_m     = '{rstn: 1'b1, fetch_en: 1'b0, pow: 1'b0, byp: 1'b1};

      add_rd(reg_info);
      add_rd(reg_fcboot);
      add_rd(reg_cluster_ctrl);
      for (int k = 0; k < 16; k++)
         add_rd(offset_idx(reg_padcfg0, k));
      for (int k = 0; k < 4; k++)
         add_wr(offset_idx(reg_padfun0, k), $urandom());
      for (int k = 0; k < 16; k++)
         add_wr(offset_idx(reg_padcfg0, k), $urandom());
      for (int k = 0; k < 4; k++)
         add_rd(offset_idx(reg_padfun0, k));
      for (int k = 0; k < 16; k++)
         add_rd(offset_idx(reg_padcfg0, k));
      add_wr(reg_fcboot, $urandom());
      add_wr(reg_cluster_boot0, $urandom());
      add_wr(reg_cluster_boot1, $urandom());
      add_rd(reg_fcboot);
      add_rd(reg_cluster_boot0);
      add_rd(reg_cluster_boot1);
      add_wr(reg_cluster_ctrl, 32'h0000000A);
      add_rd(reg_cluster_ctrl);
      add_wr(reg_corestatus, 32'h800000C3);
      add_rd(reg_corestatus);
      add_rd(reg_cs_ro);
      add_wr(reg_cs_ro, 32'h12345678);  // mirror ignores writes
      add_rd(reg_corestatus);
      add_rd(reg_cs_ro);
      add_unmapped(7'h03);
      add_unmapped(7'h1E);
      add_unmapped(7'h31);
      add_rd(reg_fcboot);
      add_rd(reg_padfun3);
      add_rd(reg_padcfg15);
      add_rd(reg_corestatus);

      repeat (2) @(posedge HCLK);
      HRESETn <= 1'b1;
      @(negedge HCLK);
      test_ok = 1'b1;
      check_outputs();
      check_word("fc_fetchen_o", 32'(fc_fetchen_o), 32'h0);
      end_test("reset outputs");

      foreach (tbl[i])
      begin
         test_ok = 1'b1;
         apb_access(tbl[i].wr, tbl[i].idx, tbl[i].wdata, 1'b0, rd);
         if (tbl[i].wr)
         begin
            model_write(tbl[i]);
            @(negedge HCLK);  // outputs settle one cycle after the access
            check_outputs();
         end
         else
            check_word($sformatf("read of %02h", tbl[i].idx), rd, tbl[i].exp);
         end_test($sformatf("%s %02h", tbl[i].wr ? "write" : "read", tbl[i].idx));
      end

      test_ok = 1'b1;
      @(posedge HCLK);
      fc_fetch_en_valid_i <= 1'b1;
      fc_fetch_en_i       <= 1'b1;
      @(posedge HCLK);
      fc_fetch_en_valid_i <= 1'b0;
      fc_fetch_en_i       <= 1'b0;
      @(negedge HCLK);
      check_word("fc_fetchen_o after strobe", 32'(fc_fetchen_o), 32'h1);
      end_test("side-band fetch enable");

      test_ok = 1'b1;
      apb_access(1'b1, reg_fcfetch, 32'h0, 1'b1, rd);
      @(negedge HCLK);
      check_word("fc_fetchen_o after write and strobe", 32'(fc_fetchen_o), 32'h0);
      end_test("fetch enable priority");

      test_ok = 1'b1;
      jtag_val = jtag_w'($urandom());
      @(posedge HCLK);
      soc_jtag_reg_i <= jtag_val;
      repeat (3) @(posedge HCLK);
      apb_access(1'b1, reg_jtagreg, 32'h000000A5, 1'b0, rd);
      apb_access(1'b0, reg_jtagreg, 32'h0, 1'b0, rd);
      check_word("jtag read", rd, {16'h0, jtag_val, 8'hA5});
      check_word("soc_jtag_reg_o", 32'(soc_jtag_reg_o), 32'h000000A5);
      end_test("jtag exchange");

      $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: soc_ctrl_assertions.sv
/*
 * APB SoC control checks
 * concurrent assertions on the top-level ports, bound to the top level
 */
`timescale 1ns/1ns
`default_nettype none

module soc_ctrl_assertions (
   input logic        HCLK,
   input logic        HRESETn,
   input logic        psel_i,
   input logic        penable_i,
   input logic [31:0] prdata_o,
   input logic        pready_o,
   input logic        pslverr_o,
   input logic        fc_fetchen_o
);

   ready_high: assert property (@(posedge HCLK) disable iff (!HRESETn) pready_o)
      else $error("pready_o went low");

   no_slverr: assert property (@(posedge HCLK) disable iff (!HRESETn) !pslverr_o)
      else $error("pslverr_o went high");

   rdata_known: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (psel_i && penable_i) |-> !$isunknown(prdata_o))
      else $error("prdata_o has unknown bits in an access phase");

   // fc must not start fetching straight out of reset
   fetch_idle: assert property (@(posedge HCLK) $rose(HRESETn) |-> !fc_fetchen_o)
      else $error("fc_fetchen_o high right after reset");

endmodule

bind apb_soc_ctrl soc_ctrl_assertions u_assert (
   .HCLK         (HCLK),
   .HRESETn      (HRESETn),
   .psel_i       (psel_i),
   .penable_i    (penable_i),
   .prdata_o     (prdata_o),
   .pready_o     (pready_o),
   .pslverr_o    (pslverr_o),
   .fc_fetchen_o (fc_fetchen_o)
);

`default_nettype wire

// File: apb_soc_ctrl.sv
/*
 * APB SoC control block
 * zero wait state APB slave over pad, boot/cluster and status registers
 */
`timescale 1ns/1ns
`default_nettype none

module apb_soc_ctrl (
   input  logic                                HCLK,
   input  logic                                HRESETn,
   input  logic [soc_ctrl_pkg::apb_addr_w-1:0] paddr_i,
   input  logic [31:0]                         pwdata_i,
   input  logic                                pwrite_i,
   input  logic                                psel_i,
   input  logic                                penable_i,
   output logic [31:0]                         prdata_o,
   output logic                                pready_o,
   output logic                                pslverr_o,
   input  logic                                fc_fetch_en_valid_i,
   input  logic                                fc_fetch_en_i,
   output soc_ctrl_pkg::pad_mux_t              pad_mux_o,
   output soc_ctrl_pkg::pad_cfg_t              pad_cfg_o,
   input  logic [soc_ctrl_pkg::jtag_w-1:0]     soc_jtag_reg_i,
   output logic [soc_ctrl_pkg::jtag_w-1:0]     soc_jtag_reg_o,
   output logic [31:0]                         fc_bootaddr_o,
   output logic                                fc_fetchen_o,
   output soc_ctrl_pkg::cluster_ctrl_t         cluster_ctrl_o,
   output logic [63:0]                         cluster_boot_addr_o
);
   import soc_ctrl_pkg::*;

   reg_wr_t     reg_wr;
   reg_addr_e   reg_idx;
   logic [31:0] pad_rdata;
   logic [31:0] boot_rdata;
   logic [31:0] stat_rdata;

   assign pready_o  = 1'b1;  // every access completes in two cycles
   assign pslverr_o = 1'b0;

   apb_slave_port u_port (
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .pwrite_i     (pwrite_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pad_rdata_i  (pad_rdata),
      .boot_rdata_i (boot_rdata),
      .stat_rdata_i (stat_rdata),
      .reg_wr_o     (reg_wr),
      .reg_idx_o    (reg_idx),
      .prdata_o     (prdata_o)
   );

   pad_ctrl_regs u_pad (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .reg_wr_i  (reg_wr),
      .reg_idx_i (reg_idx),
      .pad_mux_o (pad_mux_o),
      .pad_cfg_o (pad_cfg_o),
      .rdata_o   (pad_rdata)
   );

   boot_cluster_regs u_boot (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .reg_wr_i            (reg_wr),
      .reg_idx_i           (reg_idx),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .cluster_ctrl_o      (cluster_ctrl_o),
      .cluster_boot_addr_o (cluster_boot_addr_o),
      .rdata_o             (boot_rdata)
   );

   core_status_regs u_stat (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .reg_wr_i       (reg_wr),
      .reg_idx_i      (reg_idx),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .soc_jtag_reg_o (soc_jtag_reg_o),
      .rdata_o        (stat_rdata)
   );

endmodule

`default_nettype wire

// File: core_status_regs.sv
/*
 * Core status registers
 * info word, core status with read-only mirror, JTAG exchange register
 */
`timescale 1ns/1ns
`default_nettype none

module core_status_regs (
   input  logic                              HCLK,
   input  logic                              HRESETn,
   input  soc_ctrl_pkg::reg_wr_t             reg_wr_i,
   input  soc_ctrl_pkg::reg_addr_e           reg_idx_i,
   input  logic [soc_ctrl_pkg::jtag_w-1:0]   soc_jtag_reg_i,
   output logic [soc_ctrl_pkg::jtag_w-1:0]   soc_jtag_reg_o,
   output logic [31:0]                       rdata_o
);
   import soc_ctrl_pkg::*;

   logic [31:0]            corestatus_q;  // eoc in bit 31, status below
   logic [jtag_w-1:0]      jtag_q;
   logic [1:0][jtag_w-1:0] jtag_sync_q;  // [1] is the synchronized stage

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         corestatus_q <= '0;
         jtag_q       <= '0;
         jtag_sync_q  <= '0;
      end
      else
      begin
         jtag_sync_q <= {jtag_sync_q[0], soc_jtag_reg_i};
         if (reg_wr_i.we && reg_wr_i.idx == reg_corestatus)
            corestatus_q <= reg_wr_i.wdata;
         if (reg_wr_i.we && reg_wr_i.idx == reg_jtagreg)
            jtag_q <= reg_wr_i.wdata[jtag_w-1:0];
      end
   end

   assign soc_jtag_reg_o = jtag_q;

   always_comb
   begin
      case (reg_idx_i)
         reg_info:       rdata_o = {16'(nb_cores), 16'(nb_clusters)};
         reg_corestatus: rdata_o = corestatus_q;
         reg_cs_ro:      rdata_o = corestatus_q;
         reg_jtagreg:    rdata_o = 32'({jtag_sync_q[1], jtag_q});
         default:        rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: boot_cluster_regs.sv
/*
 * Boot and cluster registers
 * fabric controller boot address and fetch enable, cluster control
 * and the 64-bit cluster boot address
 */
`timescale 1ns/1ns
`default_nettype none

module boot_cluster_regs (
   input  logic                        HCLK,
   input  logic                        HRESETn,
   input  soc_ctrl_pkg::reg_wr_t       reg_wr_i,
   input  soc_ctrl_pkg::reg_addr_e     reg_idx_i,
   input  logic                        fc_fetch_en_valid_i,
   input  logic                        fc_fetch_en_i,
   output logic [31:0]                 fc_bootaddr_o,
   output logic                        fc_fetchen_o,
   output soc_ctrl_pkg::cluster_ctrl_t cluster_ctrl_o,
   output logic [63:0]                 cluster_boot_addr_o,
   output logic [31:0]                 rdata_o
);
   import soc_ctrl_pkg::*;

   logic [31:0]      bootaddr_q;
   logic             fetchen_q;
   cluster_ctrl_t    cluster_q;
   logic [1:0][31:0] cl_boot_q;  // [1] is the high word

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         bootaddr_q <= fc_boot_rst;
         fetchen_q  <= 1'b0;  // fc stays idle until enabled
         cluster_q  <= '{rstn: 1'b1, fetch_en: 1'b0, pow: 1'b0, byp: 1'b1};
         cl_boot_q  <= '0;
      end
      else
      begin
         if (fc_fetch_en_valid_i)
            fetchen_q <= fc_fetch_en_i;  // side-band strobe
         if (reg_wr_i.we)
         begin
            // later assignment wins, so an APB write overrides the strobe
            case (reg_wr_i.idx)
               reg_fcboot:        bootaddr_q   <= reg_wr_i.wdata;
               reg_fcfetch:       fetchen_q    <= reg_wr_i.wdata[0];
               reg_cluster_ctrl:  cluster_q    <= cluster_ctrl_t'(reg_wr_i.wdata[3:0]);
               reg_cluster_boot0: cl_boot_q[0] <= reg_wr_i.wdata;
               reg_cluster_boot1: cl_boot_q[1] <= reg_wr_i.wdata;
               default:           ;
            endcase
         end
      end
   end

   assign fc_bootaddr_o       = bootaddr_q;
   assign fc_fetchen_o        = fetchen_q;
   assign cluster_ctrl_o      = cluster_q;
   assign cluster_boot_addr_o = cl_boot_q;

   always_comb
   begin
      case (reg_idx_i)
         reg_fcboot:        rdata_o = bootaddr_q;
         reg_cluster_ctrl:  rdata_o = {28'h0, cluster_q};
         reg_cluster_boot0: rdata_o = cl_boot_q[0];
         reg_cluster_boot1: rdata_o = cl_boot_q[1];
         default:           rdata_o = '0;  // fetch enable is write only
      endcase
   end

endmodule

`default_nettype wire

// File: pad_ctrl_regs.sv
/*
 * Pad control registers
 * 64 pad function selects and 64 pad configurations with readback
 */
`timescale 1ns/1ns
`default_nettype none

module pad_ctrl_regs (
   input  logic                    HCLK,
   input  logic                    HRESETn,
   input  soc_ctrl_pkg::reg_wr_t   reg_wr_i,
   input  soc_ctrl_pkg::reg_addr_e reg_idx_i,
   output soc_ctrl_pkg::pad_mux_t  pad_mux_o,
   output soc_ctrl_pkg::pad_cfg_t  pad_cfg_o,
   output logic [31:0]             rdata_o
);
   import soc_ctrl_pkg::*;

   logic [n_fun_words-1:0][31:0] fun_q;  // word k holds pads 16k..16k+15
   pad_cfg_t                     cfg_q;
   logic [reg_idx_w-1:0]         wr_fun_off;
   logic [reg_idx_w-1:0]         wr_cfg_off;
   logic [reg_idx_w-1:0]         rd_fun_off;
   logic [reg_idx_w-1:0]         rd_cfg_off;

   // an index below base wraps to a large offset and falls out of range
   function automatic logic [reg_idx_w-1:0] word_off(input reg_addr_e idx,
                                                     input reg_addr_e base);
      return idx - base;
   endfunction

   assign wr_fun_off = word_off(reg_wr_i.idx, reg_padfun0);
   assign wr_cfg_off = word_off(reg_wr_i.idx, reg_padcfg0);
   assign rd_fun_off = word_off(reg_idx_i, reg_padfun0);
   assign rd_cfg_off = word_off(reg_idx_i, reg_padcfg0);

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         fun_q <= '0;
         cfg_q <= '1;  // all pad options on after reset
      end
      else if (reg_wr_i.we)
      begin
         if (wr_fun_off < n_fun_words)
            fun_q[wr_fun_off[fun_sel_w-1:0]] <= reg_wr_i.wdata;
         if (wr_cfg_off < n_cfg_words)
         begin
            for (int j = 0; j < pads_per_cfg_word; j++)
               cfg_q[wr_cfg_off[cfg_sel_w-1:0]*pads_per_cfg_word + j] <=
                  reg_wr_i.wdata[j*cfg_lane_w +: padcfg_w];  // top lane bits dropped
         end
      end
   end

   // two bits per pad, ascending from bit 0, so the words map straight out
   assign pad_mux_o = pad_mux_t'(fun_q);
   assign pad_cfg_o = cfg_q;

   always_comb
   begin
      rdata_o = '0;
      if (rd_fun_off < n_fun_words)
         rdata_o = fun_q[rd_fun_off[fun_sel_w-1:0]];
      else if (rd_cfg_off < n_cfg_words)
      begin
         for (int j = 0; j < pads_per_cfg_word; j++)
            rdata_o[j*cfg_lane_w +: padcfg_w] =
               cfg_q[rd_cfg_off[cfg_sel_w-1:0]*pads_per_cfg_word + j];
      end
   end

endmodule

`default_nettype wire

// File: apb_slave_port.sv
/*
 * APB slave port
 * turns an access phase into a register write command and
 * merges the read words of the register groups onto PRDATA
 */
`timescale 1ns/1ns
`default_nettype none

module apb_slave_port (
   input  logic [soc_ctrl_pkg::apb_addr_w-1:0] paddr_i,
   input  logic [31:0]                        pwdata_i,
   input  logic                               pwrite_i,
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic [31:0]                        pad_rdata_i,
   input  logic [31:0]                        boot_rdata_i,
   input  logic [31:0]                        stat_rdata_i,
   output soc_ctrl_pkg::reg_wr_t              reg_wr_o,
   output soc_ctrl_pkg::reg_addr_e            reg_idx_o,
   output logic [31:0]                        prdata_o
);
   import soc_ctrl_pkg::*;

   logic      access_wr;
   reg_addr_e word_idx;

   // word aligned, so the two low address bits are dropped
   assign word_idx = reg_addr_e'(paddr_i[reg_idx_w+1:2]);

   // access phase write, no wait states
   assign access_wr = psel_i & penable_i & pwrite_i;

   assign reg_wr_o.we    = access_wr;
   assign reg_wr_o.idx   = word_idx;
   assign reg_wr_o.wdata = pwdata_i;

   assign reg_idx_o = word_idx;

   // groups return zero outside their own registers
   assign prdata_o = pad_rdata_i | boot_rdata_i | stat_rdata_i;

endmodule

`default_nettype wire

// File: soc_ctrl_pkg.sv
/*
 * SoC control register block shared definitions
 * register map, sizes, reset values and the command and pad types
 */
`default_nettype none

package soc_ctrl_pkg;

   localparam int apb_addr_w = 12;
   localparam int reg_idx_w  = 7;  // word index from paddr[8:2]

   localparam int n_pads            = 64;
   localparam int padcfg_w          = 6;
   localparam int pads_per_fun_word = 16;
   localparam int pads_per_cfg_word = 4;
   localparam int pad_fun_w         = 32 / pads_per_fun_word;
   localparam int cfg_lane_w        = 32 / pads_per_cfg_word;
   localparam int n_fun_words       = n_pads / pads_per_fun_word;
   localparam int n_cfg_words       = n_pads / pads_per_cfg_word;
   localparam int fun_sel_w         = $clog2(n_fun_words);
   localparam int cfg_sel_w         = $clog2(n_cfg_words);

   localparam int jtag_w      = 8;
   localparam int nb_cores    = 4;
   localparam int nb_clusters = 0;

   localparam logic [31:0] fc_boot_rst = 32'h1A000080;

   typedef enum logic [reg_idx_w-1:0] {
      reg_info          = 7'h00,
      reg_fcboot        = 7'h01,
      reg_fcfetch       = 7'h02,
      reg_padfun0       = 7'h04, reg_padfun1  = 7'h05, reg_padfun2  = 7'h06, reg_padfun3  = 7'h07,
      reg_padcfg0       = 7'h08, reg_padcfg1  = 7'h09, reg_padcfg2  = 7'h0A, reg_padcfg3  = 7'h0B,
      reg_padcfg4       = 7'h0C, reg_padcfg5  = 7'h0D, reg_padcfg6  = 7'h0E, reg_padcfg7  = 7'h0F,
      reg_padcfg8       = 7'h10, reg_padcfg9  = 7'h11, reg_padcfg10 = 7'h12, reg_padcfg11 = 7'h13,
      reg_padcfg12      = 7'h14, reg_padcfg13 = 7'h15, reg_padcfg14 = 7'h16, reg_padcfg15 = 7'h17,
      reg_cluster_ctrl  = 7'h1C,
      reg_jtagreg       = 7'h1D,
      reg_cluster_boot0 = 7'h20,
      reg_cluster_boot1 = 7'h21,
      reg_corestatus    = 7'h28,
      reg_cs_ro         = 7'h30  // read-only mirror of core status
   } reg_addr_e;

   typedef struct packed {
      logic        we;     // one cycle per access phase write
      reg_addr_e   idx;
      logic [31:0] wdata;
   } reg_wr_t;

   typedef logic [n_pads-1:0][pad_fun_w-1:0] pad_mux_t;
   typedef logic [n_pads-1:0][padcfg_w-1:0]  pad_cfg_t;

   typedef struct packed {
      logic rstn;      // bit 3, active low
      logic fetch_en;  // bit 2
      logic pow;       // bit 1
      logic byp;       // bit 0
   } cluster_ctrl_t;

endpackage

`default_nettype wire
